//--- build.f
hdl/icache_pkg.sv
hdl/imem.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
testbench/fetch_tb.sv

//--- Bender.yml
package:
  name: icache_fetch

sources:
  - hdl/icache_pkg.sv
  - hdl/imem.sv
  - hdl/icache.sv
  - hdl/fetch_unit.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - testbench/fetch_tb.sv

//--- testbench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import icache_pkg::*;

    localparam int TIMEOUT = 2000;

    logic clk;
    logic rst;
    logic load_valid;
    addr_t load_addr;
    word_t load_data;
    logic flush;
    logic fetch_en;
    logic redirect;
    addr_t redirect_pc;
    logic instr_valid;
    word_t instr;
    addr_t instr_pc;
    count_t hit_count;
    count_t miss_count;

    int errors;
    int n_checks;
    logic [31:0] lfsr;

    // words written through the load port
    word_t mem_model [MEM_WORDS];

    // expected cache contents
    logic [CACHE_LINES-1:0] model_valid;
    tag_t model_tag [CACHE_LINES];
    word_t model_line [CACHE_LINES];
    count_t model_hits;
    count_t model_misses;

    // collector state
    addr_t exp_pc;
    logic resync;
    addr_t resync_pc;
    int n_collected;
    word_t last_instr;

    event run_aborted;

    fetch_top fetch_top_inst (
        .clk         (clk),
        .rst         (rst),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .flush       (flush),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        n_checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        n_checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_run;
        $display("checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("timeout after %0d cycles, %s never came", TIMEOUT, what);
        -> run_aborted;
        forever @(negedge clk);
    endtask

    // one presented instruction, looked up in the direct-mapped model
    task automatic collect(input addr_t pc, input word_t w);
        index_t idx;
        tag_t tg;
        if (resync && pc == resync_pc)
        begin
            exp_pc = resync_pc;
            resync = 1'b0;
        end
        check_addr("instr_pc", pc, exp_pc);
        idx = exp_pc[5:2];
        tg = exp_pc[11:6];
        if (model_valid[idx] && model_tag[idx] == tg)
            model_hits++;
        else
        begin
            model_misses++;
            model_valid[idx] = 1'b1;
            model_tag[idx] = tg;
            model_line[idx] = mem_model[exp_pc[11:2]];
        end
        check_word("instr", w, model_line[idx]);
        last_instr = w;
        exp_pc = exp_pc + 32'd4;
        n_collected++;
    endtask

    always @(posedge clk)
    begin
        if (!rst && instr_valid)
            collect(instr_pc, instr);
    end

    task automatic wait_collected(input int n, input string what);
        int cycles;
        cycles = 0;
        while (n_collected < n && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (n_collected < n)
            abort_run(what);
    endtask

    task automatic wait_resync(input string what);
        int cycles;
        cycles = 0;
        while (resync && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (resync)
            abort_run(what);
    endtask

    task automatic load_word(input addr_t a, input word_t d);
        @(negedge clk);
        load_valid = 1'b1;
        load_addr = a;
        load_data = d;
        mem_model[a[11:2]] = d;
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic pulse_flush;
        @(negedge clk);
        flush = 1'b1;
        model_valid = '0;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic redirect_to(input addr_t target);
        @(negedge clk);
        redirect = 1'b1;
        redirect_pc = target;
        resync_pc = target;
        resync = 1'b1;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    task automatic stop_fetch;
        int target;
        @(negedge clk);
        // outstanding request still completes, plus one already on instr_valid
        target = n_collected + (instr_valid ? 2 : 1);
        fetch_en = 1'b0;
        wait_collected(target, "last instruction after fetch stop");
    endtask

    task automatic fetch_one(input addr_t a);
        int target;
        target = n_collected + 1;
        redirect_to(a);
        fetch_en = 1'b1;
        @(negedge clk);
        fetch_en = 1'b0;
        wait_collected(target, "single fetched instruction");
    endtask

    task automatic check_counters(input count_t h0, input count_t m0,
                                  input count_t mh0, input count_t mm0);
        check_count("hit_count delta", hit_count - h0, model_hits - mh0);
        check_count("miss_count delta", miss_count - m0, model_misses - mm0);
    endtask

    task automatic test_sequential;
        word_t w;
        int i;
        for (i = 0; i < 64; i++)
        begin
            take_bits(32, w);
            load_word(addr_t'(i * 4), w);
        end
        @(negedge clk);
        fetch_en = 1'b1;
        wait_collected(40, "instruction of the sequential run");
        stop_fetch();
        check_counters('0, '0, '0, '0);
    endtask

    task automatic test_counting;
        count_t h0;
        count_t m0;
        count_t mh0;
        count_t mm0;
        int start;
        h0 = hit_count;
        m0 = miss_count;
        mh0 = model_hits;
        mm0 = model_misses;
        start = n_collected;
        redirect_to('0);
        fetch_en = 1'b1;
        wait_collected(start + 40, "instruction of the refetch run");
        stop_fetch();
        check_counters(h0, m0, mh0, mm0);
    endtask

    task automatic test_conflict;
        count_t h0;
        count_t m0;
        count_t mh0;
        count_t mm0;
        int i;
        fetch_one(32'd0);
        h0 = hit_count;
        m0 = miss_count;
        mh0 = model_hits;
        mm0 = model_misses;
        // 0 and 64 share line 0 with different tags
        for (i = 0; i < 8; i++)
        begin
            fetch_one(32'd64);
            fetch_one(32'd0);
        end
        check_count("miss_count delta", miss_count - m0, 16'd16);
        check_count("hit_count delta", hit_count - h0, 16'd0);
        check_counters(h0, m0, mh0, mm0);
    endtask

    task automatic test_redirect;
        logic [31:0] bits;
        addr_t target;
        int start;
        start = n_collected;
        redirect_to('0);
        fetch_en = 1'b1;
        wait_collected(start + 6, "instruction before the redirect");
        // words 32 to 47, far from the old path
        take_bits(4, bits);
        target = 32'd128 + {bits[3:0], 2'b00};
        redirect_to(target);
        wait_resync("instruction at the redirect target");
        start = n_collected;
        wait_collected(start + 10, "instruction after the redirect target");
        stop_fetch();
    endtask

    task automatic test_flush;
        addr_t a;
        word_t old_w;
        word_t new_w;
        count_t h0;
        count_t m0;
        a = 32'd8;
        pulse_flush();
        fetch_one(a);
        old_w = mem_model[a[11:2]];
        new_w = ~old_w;
        load_word(a, new_w);
        h0 = hit_count;
        m0 = miss_count;
        fetch_one(a);
        check_word("stale instr", last_instr, old_w);
        // the line is still valid, so this lookup hits
        check_count("hit_count delta", hit_count - h0, 16'd1);
        check_count("miss_count delta", miss_count - m0, 16'd0);
        h0 = hit_count;
        m0 = miss_count;
        pulse_flush();
        fetch_one(a);
        check_word("instr after flush", last_instr, new_w);
        check_count("miss_count delta", miss_count - m0, 16'd1);
        check_count("hit_count delta", hit_count - h0, 16'd0);
    endtask

    initial
    begin
        rst = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_data = '0;
        flush = 1'b0;
        fetch_en = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        errors = 0;
        n_checks = 0;
        lfsr = 32'h5dab_3516;
        model_valid = '0;
        model_hits = '0;
        model_misses = '0;
        exp_pc = '0;
        resync = 1'b0;
        resync_pc = '0;
        n_collected = 0;
        last_instr = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_sequential();
        test_counting();
        test_conflict();
        test_redirect();
        test_flush();
        finish_run();
    end

    initial
    begin
        @(run_aborted);
        finish_run();
    end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_valid,
    input  icache_pkg::addr_t  load_addr,
    input  icache_pkg::word_t  load_data,
    input  logic               flush,
    input  logic               fetch_en,
    input  logic               redirect,
    input  icache_pkg::addr_t  redirect_pc,
    output logic               instr_valid,
    output icache_pkg::word_t  instr,
    output icache_pkg::addr_t  instr_pc,
    output icache_pkg::count_t hit_count,
    output icache_pkg::count_t miss_count
);
    import icache_pkg::*;

    // fetch unit to cache
    logic req_valid;
    addr_t req_addr;
    logic resp_ready;
    word_t resp_data;

    // cache to memory
    logic mem_valid;
    mem_addr_t mem_addr;
    logic mem_ready;
    word_t mem_data;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .resp_ready  (resp_ready),
        .resp_data   (resp_data),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    icache icache_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .mem_ready  (mem_ready),
        .mem_data   (mem_data),
        .resp_ready (resp_ready),
        .resp_data  (resp_data),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    imem imem_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .mem_ready  (mem_ready),
        .mem_data   (mem_data)
    );

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_en,
    input  logic              redirect,
    input  icache_pkg::addr_t redirect_pc,
    input  logic              resp_ready,
    input  icache_pkg::word_t resp_data,
    output logic              req_valid,
    output icache_pkg::addr_t req_addr,
    output logic              instr_valid,
    output icache_pkg::word_t instr,
    output icache_pkg::addr_t instr_pc
);
    import icache_pkg::*;

    addr_t pc;
    addr_t pc_next;
    logic discard;
    logic req_done;
    logic keep;

    assign req_done = req_valid && resp_ready;

    // a redirect in the response cycle also drops that response
    assign keep = req_done && !discard && !redirect;

    always_comb
    begin
        pc_next = pc;
        if (redirect)
            pc_next = redirect_pc;
        else if (keep)
            pc_next = req_addr + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc          <= '0;
            req_valid   <= 1'b0;
            discard     <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            pc          <= pc_next;
            instr_valid <= keep;

            if (!req_valid || req_done)
                req_valid <= fetch_en;

            if (req_done)
                discard <= 1'b0;
            else if (req_valid && redirect)
                discard <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!req_valid || req_done)
            req_addr <= pc_next;
        if (keep)
        begin
            instr    <= resp_data;
            instr_pc <= req_addr;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !resp_ready |=> req_valid && $stable(req_addr));

endmodule

//--- hdl/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  req_valid,
    input  icache_pkg::addr_t     req_addr,
    input  logic                  mem_ready,
    input  icache_pkg::word_t     mem_data,
    output logic                  resp_ready,
    output icache_pkg::word_t     resp_data,
    output logic                  mem_valid,
    output icache_pkg::mem_addr_t mem_addr,
    output icache_pkg::count_t    hit_count,
    output icache_pkg::count_t    miss_count
);
    import icache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;

    addr_t req_addr_q;
    index_t idx;
    tag_t tag;
    logic hit;

    logic [CACHE_LINES-1:0] valid;
    tag_t tags [CACHE_LINES];
    word_t data [CACHE_LINES];

    logic flush_pending;
    logic flush_now;
    logic refilled;
    logic line_write;

    assign idx = req_addr_q[5:2];
    assign tag = req_addr_q[11:6];
    assign hit = valid[idx] && (tags[idx] == tag);

    assign resp_ready = (state == LOOKUP) && hit;
    assign resp_data  = data[idx];
    assign mem_valid  = (state == REFILL);
    assign mem_addr   = req_addr_q[11:2];

    assign line_write = (state == REFILL) && mem_ready;

    // flush waits for the end of a request unless idle
    assign flush_now = (flush || flush_pending) && ((state == IDLE) || resp_ready);

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (req_valid)
                    state_next = LOOKUP;
            end
            LOOKUP:
            begin
                state_next = hit ? IDLE : REFILL;
            end
            REFILL:
            begin
                if (mem_ready)
                    state_next = LOOKUP;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= IDLE;
            valid         <= '0;
            flush_pending <= 1'b0;
            refilled      <= 1'b0;
        end
        else
        begin
            state <= state_next;

            if (flush_now)
            begin
                valid         <= '0;
                flush_pending <= 1'b0;
            end
            else
            begin
                if (flush)
                    flush_pending <= 1'b1;
                if (line_write)
                    valid[idx] <= 1'b1;
            end

            // second lookup after a refill is not counted again
            if (line_write)
                refilled <= 1'b1;
            else if (state == IDLE)
                refilled <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else if (state == LOOKUP && !refilled)
        begin
            if (hit)
            begin
                if (hit_count != '1)
                    hit_count <= hit_count + 1'b1;
            end
            else if (miss_count != '1)
            begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // request address and line storage
    always_ff @(posedge clk)
    begin
        if (state == IDLE && req_valid)
            req_addr_q <= req_addr;
        if (line_write)
        begin
            tags[idx] <= tag;
            data[idx] <= mem_data;
        end
    end

    // response only while the fetch unit still holds its request
    a_resp_in_lookup: assert property (@(posedge clk) disable iff (rst)
        resp_ready |-> (state == LOOKUP) && req_valid);

    // request kept unchanged while its line is refilled
    a_req_held_in_refill: assert property (@(posedge clk) disable iff (rst)
        mem_valid |-> req_valid && (req_addr == req_addr_q));

    a_mem_ready_in_refill: assert property (@(posedge clk) disable iff (rst)
        mem_ready |-> (state == REFILL));

endmodule

//--- hdl/imem.sv
`timescale 1ns/1ps

module imem (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_valid,
    input  icache_pkg::mem_addr_t mem_addr,
    input  logic                  load_valid,
    input  icache_pkg::addr_t     load_addr,
    input  icache_pkg::word_t     load_data,
    output logic                  mem_ready,
    output icache_pkg::word_t     mem_data
);
    import icache_pkg::*;

    word_t mem [MEM_WORDS];

    mem_addr_t rd_addr;
    logic busy;
    logic accept;
    logic [LAT_W-1:0] wait_cnt;

    // a new read is not taken while the ready pulse is out
    assign accept = mem_valid && !busy && !mem_ready;

    always_ff @(posedge clk)
    begin
        if (load_valid)
            mem[load_addr[11:2]] <= load_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            mem_ready <= 1'b0;
            wait_cnt  <= '0;
        end
        else
        begin
            mem_ready <= 1'b0;
            if (busy)
            begin
                if (wait_cnt == '0)
                begin
                    busy      <= 1'b0;
                    mem_ready <= 1'b1;
                end
                else
                begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
            else if (accept)
            begin
                busy     <= 1'b1;
                wait_cnt <= LAT_W'(MEM_LATENCY - 2);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            rd_addr <= mem_addr;
        if (busy && wait_cnt == '0)
            mem_data <= mem[rd_addr];
    end

    a_no_load_during_read: assert property (@(posedge clk) disable iff (rst)
        !(load_valid && mem_valid));

endmodule

//--- hdl/icache_pkg.sv
package icache_pkg;

    // sizes
    localparam int CACHE_LINES = 16;
    localparam int MEM_WORDS   = 1024;
    localparam int MEM_LATENCY = 3;

    // width of the imem latency counter
    localparam int LAT_W = $clog2(MEM_LATENCY);

    // byte address, only bits 11:2 reach memory
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;

    // address bits 5:2
    typedef logic [3:0] index_t;

    // address bits 11:6
    typedef logic [5:0] tag_t;

    // address bits 11:2
    typedef logic [9:0] mem_addr_t;

    // saturating performance counter
    typedef logic [15:0] count_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } cache_state_t;

endpackage
